/* logic/datapath_pkg.sv */
`default_nettype none

package datapath_pkg;

    // one execution lane per issue slot
    localparam int NUM_SLOTS = 2;
    localparam int NUM_REGS = 32;
    localparam int DATA_W = 32;
    localparam int IMM_W = 16;
    // source a and source b for every slot
    localparam int NUM_RD_PORTS = 2 * NUM_SLOTS;

    typedef logic [DATA_W-1:0] word_t;
    // product, or hi in the upper half and lo in the lower half
    typedef logic [2*DATA_W-1:0] dword_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0] imm_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_MULT,
        OP_MADD,
        OP_MSUB,
        OP_MTHI,
        OP_MTLO,
        OP_MFHI,
        OP_MFLO
    } op_e;

    // pair split machine
    typedef enum logic {
        ISSUE_PAIR,
        ISSUE_SECOND
    } issue_state_e;

    // alu ops and hi/lo moves into a gpr
    function automatic logic op_writes_reg(op_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI,
                          OP_MFHI, OP_MFLO};
    endfunction

endpackage

`default_nettype wire

/* logic/issue_if.sv */
`default_nettype none

interface issue_if;
    import datapath_pkg::*;

    // one instruction, operands already read and forwarded
    logic valid;
    op_e op;
    reg_idx_t dst;
    word_t src_a_val;
    word_t src_b_val;
    // raw immediate, lane does the sign extension
    imm_t imm;

    modport sender (output valid, op, dst, src_a_val, src_b_val, imm);
    modport receiver (input valid, op, dst, src_a_val, src_b_val, imm);

endinterface

`default_nettype wire

/* logic/result_if.sv */
`default_nettype none

interface result_if;
    import datapath_pkg::*;

    // registered lane output, one cycle after issue
    logic valid;
    op_e op;
    reg_idx_t dst;
    // alu result, or the moved operand for mthi/mtlo/mfhi/mflo
    word_t result;
    // signed 64-bit product for mult/madd/msub
    dword_t product;

    modport sender (output valid, op, dst, result, product);
    modport receiver (input valid, op, dst, result, product);

endinterface

`default_nettype wire

/* logic/wb_if.sv */
`default_nettype none

interface wb_if;
    import datapath_pkg::*;

    // one write port per slot, slot 1 is the younger one
    logic [NUM_SLOTS-1:0] wr_en;
    reg_idx_t wr_addr [NUM_SLOTS];
    word_t wr_data [NUM_SLOTS];
    // hi/lo as they stand once the pair in writeback is applied
    word_t hi;
    word_t lo;

    modport sender (output wr_en, wr_addr, wr_data, hi, lo);
    // register file only needs the write ports
    modport receiver (input wr_en, wr_addr, wr_data);
    // issue unit forwards gpr results and hi/lo
    modport fwd (input wr_en, wr_addr, wr_data, hi, lo);

endinterface

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic clk,
    input  logic reset,
    input  datapath_pkg::reg_idx_t i_rd_addr [datapath_pkg::NUM_RD_PORTS],
    output datapath_pkg::word_t o_rd_data [datapath_pkg::NUM_RD_PORTS],
    wb_if.receiver i_wb
);
    import datapath_pkg::*;

    word_t regs [NUM_REGS];

    // both ports in one edge, loop order lets slot 1 win on equal address
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                // r0 is never written
                if (i_wb.wr_en[s] && i_wb.wr_addr[s] != '0) begin
                    regs[i_wb.wr_addr[s]] <= i_wb.wr_data[s];
                end
            end
        end
    end

    // asynchronous reads, r0 reads as zero
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            if (i_rd_addr[p] == '0) begin
                o_rd_data[p] = '0;
            end else begin
                o_rd_data[p] = regs[i_rd_addr[p]];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/issue_unit.sv */
`default_nettype none

module issue_unit (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    output logic o_ready,
    input  datapath_pkg::op_e i_op [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_dst [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_src_a [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_src_b [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::imm_t i_imm [datapath_pkg::NUM_SLOTS],
    output datapath_pkg::reg_idx_t o_rd_addr [datapath_pkg::NUM_RD_PORTS],
    input  datapath_pkg::word_t i_rd_data [datapath_pkg::NUM_RD_PORTS],
    wb_if.fwd i_wb,
    issue_if.sender o_iss0,
    issue_if.sender o_iss1
);
    import datapath_pkg::*;

    issue_state_e state_q;
    issue_state_e state_d;
    logic dep;
    logic [NUM_SLOTS-1:0] slot_go;
    reg_idx_t src [NUM_RD_PORTS];
    word_t opnd [NUM_RD_PORTS];

    // port 2s is source a of slot s, port 2s+1 source b
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            src[2*s] = i_src_a[s];
            src[2*s+1] = i_src_b[s];
        end
    end

    assign o_rd_addr = src;

    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            opnd[p] = i_rd_data[p];
            // later slot overrides, so slot 1 has priority
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (i_wb.wr_en[s] && i_wb.wr_addr[s] == src[p] && src[p] != '0) begin
                    opnd[p] = i_wb.wr_data[s];
                end
            end
        end
        // hi/lo moves read the forwarded accumulator on source a
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (i_op[s] == OP_MFHI) begin
                opnd[2*s] = i_wb.hi;
            end else if (i_op[s] == OP_MFLO) begin
                opnd[2*s] = i_wb.lo;
            end
        end
    end

    // slot 1 needs the gpr that slot 0 is about to write
    assign dep = op_writes_reg(i_op[0]) && i_dst[0] != '0
        && (i_src_a[1] == i_dst[0] || i_src_b[1] == i_dst[0]);

    always_comb begin
        state_d = state_q;
        slot_go = '0;
        o_ready = 1'b1;
        case (state_q)
            ISSUE_PAIR: begin
                if (i_valid && dep) begin
                    // slot 0 alone, pair stays at the input
                    slot_go[0] = 1'b1;
                    o_ready = 1'b0;
                    state_d = ISSUE_SECOND;
                end else if (i_valid) begin
                    slot_go = '1;
                end
            end
            ISSUE_SECOND: begin
                // slot 0 is now on the writeback ports
                slot_go[1] = i_valid;
                if (i_valid) begin
                    state_d = ISSUE_PAIR;
                end
            end
            default: begin
                state_d = ISSUE_PAIR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ISSUE_PAIR;
        end else begin
            state_q <= state_d;
        end
    end

    // lane 0 gets slot 0, lane 1 gets slot 1
    assign o_iss0.valid = slot_go[0];
    assign o_iss0.op = i_op[0];
    assign o_iss0.dst = i_dst[0];
    assign o_iss0.src_a_val = opnd[0];
    assign o_iss0.src_b_val = opnd[1];
    assign o_iss0.imm = i_imm[0];

    assign o_iss1.valid = slot_go[1];
    assign o_iss1.op = i_op[1];
    assign o_iss1.dst = i_dst[1];
    assign o_iss1.src_a_val = opnd[2];
    assign o_iss1.src_b_val = opnd[3];
    assign o_iss1.imm = i_imm[1];

endmodule

`default_nettype wire

/* logic/exec_lane.sv */
`default_nettype none

module exec_lane (
    input  logic clk,
    input  logic reset,
    issue_if.receiver i_iss,
    result_if.sender o_res
);
    import datapath_pkg::*;

    word_t imm_ext;
    word_t alu_out;
    dword_t a_ext;
    dword_t b_ext;
    dword_t prod;

    assign imm_ext = {{(DATA_W-IMM_W){i_iss.imm[IMM_W-1]}}, i_iss.imm};

    // sign extend first, low 64 bits of the product are the signed result
    assign a_ext = {{DATA_W{i_iss.src_a_val[DATA_W-1]}}, i_iss.src_a_val};
    assign b_ext = {{DATA_W{i_iss.src_b_val[DATA_W-1]}}, i_iss.src_b_val};
    assign prod = a_ext * b_ext;

    always_comb begin
        case (i_iss.op)
            OP_ADD: alu_out = i_iss.src_a_val + i_iss.src_b_val;
            OP_SUB: alu_out = i_iss.src_a_val - i_iss.src_b_val;
            OP_AND: alu_out = i_iss.src_a_val & i_iss.src_b_val;
            OP_OR: alu_out = i_iss.src_a_val | i_iss.src_b_val;
            OP_XOR: alu_out = i_iss.src_a_val ^ i_iss.src_b_val;
            OP_SLT: alu_out = word_t'($signed(i_iss.src_a_val) < $signed(i_iss.src_b_val));
            OP_ADDI: alu_out = i_iss.src_a_val + imm_ext;
            // moves pass source a straight through
            OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO: alu_out = i_iss.src_a_val;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_res.valid <= 1'b0;
        end else begin
            o_res.valid <= i_iss.valid;
        end
    end

    // payload follows valid
    always_ff @(posedge clk) begin
        o_res.op <= i_iss.op;
        o_res.dst <= i_iss.dst;
        o_res.result <= alu_out;
        o_res.product <= prod;
    end

endmodule

`default_nettype wire

/* logic/writeback_merge.sv */
`default_nettype none

module writeback_merge (
    input  logic clk,
    input  logic reset,
    result_if.receiver i_res0,
    result_if.receiver i_res1,
    wb_if.sender o_wb,
    output datapath_pkg::word_t o_hi,
    output datapath_pkg::word_t o_lo
);
    import datapath_pkg::*;

    word_t hi_q;
    word_t lo_q;
    dword_t hilo_w;
    logic hi_touched;
    logic lo_touched;
    logic lane_vld [NUM_SLOTS];
    op_e lane_op [NUM_SLOTS];
    reg_idx_t lane_dst [NUM_SLOTS];
    word_t lane_res [NUM_SLOTS];
    dword_t lane_prod [NUM_SLOTS];
    word_t wb_val [NUM_SLOTS];

    // gather both lanes so the walk can index by slot
    always_comb begin
        lane_vld[0] = i_res0.valid;
        lane_op[0] = i_res0.op;
        lane_dst[0] = i_res0.dst;
        lane_res[0] = i_res0.result;
        lane_prod[0] = i_res0.product;
        lane_vld[1] = i_res1.valid;
        lane_op[1] = i_res1.op;
        lane_dst[1] = i_res1.dst;
        lane_res[1] = i_res1.result;
        lane_prod[1] = i_res1.product;
    end

    // program order walk, slot 0 then slot 1
    always_comb begin
        hilo_w = {hi_q, lo_q};
        hi_touched = 1'b0;
        lo_touched = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            wb_val[s] = lane_res[s];
            if (lane_vld[s]) begin
                case (lane_op[s])
                    OP_MULT: begin
                        hilo_w = lane_prod[s];
                        hi_touched = 1'b1;
                        lo_touched = 1'b1;
                    end
                    OP_MADD: begin
                        hilo_w = hilo_w + lane_prod[s];
                        hi_touched = 1'b1;
                        lo_touched = 1'b1;
                    end
                    OP_MSUB: begin
                        hilo_w = hilo_w - lane_prod[s];
                        hi_touched = 1'b1;
                        lo_touched = 1'b1;
                    end
                    OP_MTHI: begin
                        hilo_w[2*DATA_W-1:DATA_W] = lane_res[s];
                        hi_touched = 1'b1;
                    end
                    OP_MTLO: begin
                        hilo_w[DATA_W-1:0] = lane_res[s];
                        lo_touched = 1'b1;
                    end
                    // lane value is hi/lo at pair start, older slot may have moved it
                    OP_MFHI: begin
                        if (hi_touched) begin
                            wb_val[s] = hilo_w[2*DATA_W-1:DATA_W];
                        end
                    end
                    OP_MFLO: begin
                        if (lo_touched) begin
                            wb_val[s] = hilo_w[DATA_W-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o_wb.wr_en[s] = lane_vld[s] && op_writes_reg(lane_op[s]) && lane_dst[s] != '0;
            o_wb.wr_addr[s] = lane_dst[s];
            o_wb.wr_data[s] = wb_val[s];
        end
    end

    // forwarded to issue for mfhi/mflo
    assign o_wb.hi = hilo_w[2*DATA_W-1:DATA_W];
    assign o_wb.lo = hilo_w[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            {hi_q, lo_q} <= hilo_w;
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

endmodule

`default_nettype wire

/* logic/dual_issue_core.sv */
`default_nettype none

module dual_issue_core (
    input  logic clk,
    input  logic reset,
    input  logic i_valid,
    output logic o_ready,
    input  datapath_pkg::op_e i_op [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_dst [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_src_a [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::reg_idx_t i_src_b [datapath_pkg::NUM_SLOTS],
    input  datapath_pkg::imm_t i_imm [datapath_pkg::NUM_SLOTS],
    output logic [datapath_pkg::NUM_SLOTS-1:0] o_wb_valid,
    output datapath_pkg::reg_idx_t o_wb_addr [datapath_pkg::NUM_SLOTS],
    output datapath_pkg::word_t o_wb_data [datapath_pkg::NUM_SLOTS],
    output datapath_pkg::word_t o_hi,
    output datapath_pkg::word_t o_lo
);
    import datapath_pkg::*;

    reg_idx_t rd_addr [NUM_RD_PORTS];
    word_t rd_data [NUM_RD_PORTS];

    issue_if u_iss_if [NUM_SLOTS] ();
    result_if u_res_if [NUM_SLOTS] ();
    wb_if u_wb_if ();

    reg_file u_reg_file (
        .clk,
        .reset,
        .i_rd_addr(rd_addr),
        .o_rd_data(rd_data),
        .i_wb(u_wb_if)
    );

    issue_unit u_issue (
        .clk,
        .reset,
        .i_valid,
        .o_ready,
        .i_op,
        .i_dst,
        .i_src_a,
        .i_src_b,
        .i_imm,
        .o_rd_addr(rd_addr),
        .i_rd_data(rd_data),
        .i_wb(u_wb_if),
        .o_iss0(u_iss_if[0]),
        .o_iss1(u_iss_if[1])
    );

    // identical lanes, one per slot
    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_lane
        exec_lane u_lane (
            .clk,
            .reset,
            .i_iss(u_iss_if[g]),
            .o_res(u_res_if[g])
        );
    end

    writeback_merge u_wb_merge (
        .clk,
        .reset,
        .i_res0(u_res_if[0]),
        .i_res1(u_res_if[1]),
        .o_wb(u_wb_if),
        .o_hi,
        .o_lo
    );

    // writeback ports leave the core as they go to the register file
    assign o_wb_valid = u_wb_if.wr_en;
    assign o_wb_addr = u_wb_if.wr_addr;
    assign o_wb_data = u_wb_if.wr_data;

endmodule

`default_nettype wire

/* dv/dual_issue_core_assert.sv */
`default_nettype none

module dual_issue_core_assert (
    input logic clk,
    input logic reset,
    input logic i_ready,
    input logic [datapath_pkg::NUM_SLOTS-1:0] i_wb_valid,
    input datapath_pkg::reg_idx_t i_wb_addr [datapath_pkg::NUM_SLOTS]
);
    import datapath_pkg::*;

    // a split stalls the input for one cycle only
    a_ready_recovers: assert property (@(posedge clk) disable iff (reset) !i_ready |=> i_ready)
        else $error("o_ready low in two consecutive cycles");

    // r0 is never a writeback target
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
            i_wb_valid[s] |-> i_wb_addr[s] != '0)
            else $error("writeback to r0 on slot %0d", s);
    end

    // lanes leave reset empty
    a_quiet_after_reset: assert property (@(posedge clk) $past(reset) |-> i_wb_valid == '0)
        else $error("o_wb_valid high in the cycle after reset");

endmodule

bind dual_issue_core dual_issue_core_assert u_assert (
    .clk(clk),
    .reset(reset),
    .i_ready(o_ready),
    .i_wb_valid(o_wb_valid),
    .i_wb_addr(o_wb_addr)
);

`default_nettype wire

/* dv/dual_issue_core_tb.sv */
`default_nettype none

module dual_issue_core_tb;
    import datapath_pkg::*;

    localparam int NUM_FIXED = 14;
    localparam int NUM_TESTS = NUM_FIXED + 26;
    localparam int RESET_CYCLES = 16;
    // room for a split on every pair, plus reset and drain
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 4 + 40;

    typedef struct packed {
        op_e op;
        reg_idx_t dst;
        reg_idx_t src_a;
        reg_idx_t src_b;
        imm_t imm;
    } slot_t;

    logic clk = 1'b0;
    logic reset;
    logic i_valid;
    logic o_ready;
    op_e i_op [NUM_SLOTS];
    reg_idx_t i_dst [NUM_SLOTS];
    reg_idx_t i_src_a [NUM_SLOTS];
    reg_idx_t i_src_b [NUM_SLOTS];
    imm_t i_imm [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] o_wb_valid;
    reg_idx_t o_wb_addr [NUM_SLOTS];
    word_t o_wb_data [NUM_SLOTS];
    word_t o_hi;
    word_t o_lo;

    slot_t tbl [NUM_TESTS][NUM_SLOTS];
    int seed = 32'hc13;

    // architectural state of the reference model
    word_t model_regs [NUM_REGS];
    word_t model_hi;
    word_t model_lo;
    // writeback due at the next falling edge
    logic exp_valid [NUM_SLOTS];
    reg_idx_t exp_addr [NUM_SLOTS];
    word_t exp_data [NUM_SLOTS];
    // hi/lo once that writeback lands, and what o_hi/o_lo show now
    word_t wb_hi;
    word_t wb_lo;
    word_t cur_hi;
    word_t cur_lo;

    dual_issue_core u_dut (
        .clk,
        .reset,
        .i_valid,
        .o_ready,
        .i_op,
        .i_dst,
        .i_src_a,
        .i_src_b,
        .i_imm,
        .o_wb_valid,
        .o_wb_addr,
        .o_wb_data,
        .o_hi,
        .o_lo
    );

    always #5 clk = ~clk;

    function automatic logic writes_gpr(op_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_MFHI, OP_MFLO: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // bit 0 source a, bit 1 source b
    function automatic logic [1:0] reads_src(op_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: return 2'b11;
            OP_MULT, OP_MADD, OP_MSUB: return 2'b11;
            OP_ADDI, OP_MTHI, OP_MTLO: return 2'b01;
            default: return 2'b00;
        endcase
    endfunction

    // unused source fields are zeroed
    function automatic slot_t make_slot(op_e op, int dst, int src_a, int src_b, int imm);
        slot_t sl;
        logic [1:0] rd;
        rd = reads_src(op);
        sl.op = op;
        sl.dst = reg_idx_t'(dst);
        sl.src_a = rd[0] ? reg_idx_t'(src_a) : '0;
        sl.src_b = rd[1] ? reg_idx_t'(src_b) : '0;
        sl.imm = imm_t'(imm);
        return sl;
    endfunction

    // slot 1 reads what slot 0 writes
    function automatic logic depends_on_slot0(slot_t s0, slot_t s1);
        return writes_gpr(s0.op) && s0.dst != '0
            && (s1.src_a == s0.dst || s1.src_b == s0.dst);
    endfunction

    task automatic set_pair(input int t, input op_e op0, input int d0, input int a0, input int b0,
                            input int imm0, input op_e op1, input int d1, input int a1,
                            input int b1, input int imm1);
        tbl[t][0] = make_slot(op0, d0, a0, b0, imm0);
        tbl[t][1] = make_slot(op1, d1, a1, b1, imm1);
    endtask

    task automatic build_table();
        word_t r;
        // op, dst, src a, src b, imm for slot 0 and then slot 1
        set_pair(0, OP_ADDI, 1, 0, 0, 100, OP_ADDI, 2, 0, 0, -7);
        set_pair(1, OP_ADD, 3, 1, 2, 0, OP_SLT, 4, 2, 1, 0);
        // r5 feeds slot 1, so this pair splits
        set_pair(2, OP_SUB, 5, 3, 1, 0, OP_XOR, 6, 5, 4, 0);
        set_pair(3, OP_AND, 7, 6, 3, 0, OP_OR, 8, 5, 4, 0);
        set_pair(4, OP_MULT, 0, 1, 2, 0, OP_MFHI, 9, 0, 0, 0);
        set_pair(5, OP_MADD, 0, 3, 3, 0, OP_MSUB, 0, 2, 6, 0);
        set_pair(6, OP_MFLO, 10, 0, 0, 0, OP_MTHI, 0, 8, 0, 0);
        set_pair(7, OP_MTLO, 0, 1, 0, 0, OP_MFHI, 11, 0, 0, 0);
        // same target in both slots
        set_pair(8, OP_ADDI, 12, 0, 0, 11, OP_ADDI, 12, 0, 0, 22);
        set_pair(9, OP_ADD, 13, 12, 1, 0, OP_SLT, 14, 0, 12, 0);
        // write to r0 and read of r0
        set_pair(10, OP_ADDI, 0, 1, 0, 5, OP_ADD, 15, 0, 12, 0);
        set_pair(11, OP_SUB, 16, 0, 12, 0, OP_NOP, 0, 0, 0, 0);
        set_pair(12, OP_MULT, 0, 2, 2, 0, OP_MFLO, 17, 0, 0, 0);
        set_pair(13, OP_MSUB, 0, 16, 16, 0, OP_MFHI, 18, 0, 0, 0);
        // random tail on r0..r7 so dependencies are frequent
        for (int t = NUM_FIXED; t < NUM_TESTS; t++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                r = $random(seed);
                tbl[t][s] = make_slot(op_e'(r[3:0] % 4'd14 + 4'd1), int'(r[7:5]),
                    int'(r[10:8]), int'(r[13:11]), int'(r[31:16]));
            end
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_wb(input int slot, input reg_idx_t want_addr, input word_t want_data);
        if (o_wb_addr[slot] !== want_addr) begin
            stop_on_error($sformatf("mismatch o_wb_addr[%0d] got %h expected %h", slot,
                o_wb_addr[slot], want_addr));
        end
        if (o_wb_data[slot] !== want_data) begin
            stop_on_error($sformatf("mismatch o_wb_data[%0d] got %h expected %h", slot,
                o_wb_data[slot], want_data));
        end
    endtask

    task automatic check_hilo(input word_t want_hi, input word_t want_lo);
        if (o_hi !== want_hi) begin
            stop_on_error($sformatf("mismatch o_hi got %h expected %h", o_hi, want_hi));
        end
        if (o_lo !== want_lo) begin
            stop_on_error($sformatf("mismatch o_lo got %h expected %h", o_lo, want_lo));
        end
    endtask

    // one instruction in program order on the model state
    task automatic run_model(input int s, input slot_t sl);
        word_t a;
        word_t b;
        word_t res;
        longint pa;
        longint pb;
        logic [63:0] hilo;
        a = model_regs[sl.src_a];
        b = model_regs[sl.src_b];
        pa = longint'($signed(a));
        pb = longint'($signed(b));
        hilo = {model_hi, model_lo};
        res = '0;
        case (sl.op)
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_OR: res = a | b;
            OP_XOR: res = a ^ b;
            OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: res = a + {{16{sl.imm[15]}}, sl.imm};
            OP_MULT: hilo = pa * pb;
            OP_MADD: hilo = hilo + (pa * pb);
            OP_MSUB: hilo = hilo - (pa * pb);
            OP_MTHI: hilo[63:32] = a;
            OP_MTLO: hilo[31:0] = a;
            OP_MFHI: res = model_hi;
            OP_MFLO: res = model_lo;
            default: res = '0;
        endcase
        {model_hi, model_lo} = hilo;
        exp_valid[s] = writes_gpr(sl.op) && sl.dst != '0;
        exp_addr[s] = sl.dst;
        exp_data[s] = res;
        if (exp_valid[s]) begin
            model_regs[sl.dst] = res;
        end
    endtask

    // outputs here are registered, stable through the low phase
    task automatic check_cycle();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (o_wb_valid[s] && !exp_valid[s]) begin
                stop_on_error($sformatf("unexpected writeback on slot %0d", s));
            end else if (!o_wb_valid[s] && exp_valid[s]) begin
                stop_on_error($sformatf("missing writeback on slot %0d", s));
            end else if (exp_valid[s]) begin
                check_wb(s, exp_addr[s], exp_data[s]);
            end
        end
        check_hilo(cur_hi, cur_lo);
        cur_hi = wb_hi;
        cur_lo = wb_lo;
    endtask

    initial begin
        logic dep;
        logic split_seen;
        logic moved;
        reset = 1'b1;
        i_valid = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            i_op[s] = OP_NOP;
            i_dst[s] = '0;
            i_src_a[s] = '0;
            i_src_b[s] = '0;
            i_imm[s] = '0;
            exp_valid[s] = 1'b0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        model_hi = '0;
        model_lo = '0;
        wb_hi = '0;
        wb_lo = '0;
        cur_hi = '0;
        cur_lo = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            dep = depends_on_slot0(tbl[t][0], tbl[t][1]);
            split_seen = 1'b0;
            moved = 1'b0;
            i_valid = 1'b1;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                i_op[s] = tbl[t][s].op;
                i_dst[s] = tbl[t][s].dst;
                i_src_a[s] = tbl[t][s].src_a;
                i_src_b[s] = tbl[t][s].src_b;
                i_imm[s] = tbl[t][s].imm;
            end
            // pair held until it transfers
            while (!moved) begin
                // o_ready settles after the new inputs
                #1;
                if (!o_ready) begin
                    if (!dep || split_seen) begin
                        stop_on_error($sformatf("o_ready dropped without cause on pair %0d", t));
                    end
                    // slot 0 goes alone
                    split_seen = 1'b1;
                    run_model(0, tbl[t][0]);
                    exp_valid[1] = 1'b0;
                end else begin
                    if (dep && !split_seen) begin
                        stop_on_error($sformatf("dependent pair %0d was not split", t));
                    end
                    if (split_seen) begin
                        exp_valid[0] = 1'b0;
                    end else begin
                        run_model(0, tbl[t][0]);
                    end
                    run_model(1, tbl[t][1]);
                    moved = 1'b1;
                end
                wb_hi = model_hi;
                wb_lo = model_lo;
                @(negedge clk);
                check_cycle();
            end
        end
        // drain, last hi/lo update shows one cycle later
        i_valid = 1'b0;
        exp_valid[0] = 1'b0;
        exp_valid[1] = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_cycle();
        end
        $display("Test completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        stop_on_error($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
    end

endmodule

`default_nettype wire

/* dual_issue_core.f */
logic/datapath_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/wb_if.sv
logic/reg_file.sv
logic/issue_unit.sv
logic/exec_lane.sv
logic/writeback_merge.sv
logic/dual_issue_core.sv
dv/dual_issue_core_assert.sv
dv/dual_issue_core_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := dual_issue_core_tb
FILELIST := dual_issue_core.f
BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
PASS_MSG := Test completed successfully

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
